//--- project.f
+incdir+source
source/fp_fmt_pkg.sv
source/fp_op_pkg.sv
source/fp_lane_pipe.sv
source/fp_noncomp_lane.sv
source/fp_result_packer.sv
source/fp_noncomp_slice.sv
dv/fp_slice_props.sv
dv/fp_slice_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := fp_slice_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_TEXT := Simulation PASSED

# Sources from the file list plus the shared header
SOURCES   := $(shell grep -v '^+' $(FILELIST)) source/fp_slice_defs.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/slice_cases.hex
// op fmt vec operand_a operand_b tag result status
// op 0 MIN 1 MAX 2 SGNJ 3 SGNJN 4 SGNJX, fmt 0 FP32 1 FP16, status bit 4 is NV
0 0 0 3f800000 40000000 01 3f800000 00
1 0 0 3f800000 40000000 02 40000000 00
0 0 0 00000000 80000000 03 80000000 00
1 0 0 80000000 00000000 04 00000000 00
0 0 0 7fc00000 bf800000 05 bf800000 00
1 0 0 c0400000 7f800001 06 c0400000 10
0 0 0 7f800001 7fc00000 07 7fc00000 10
1 0 0 ffc12345 7fc00001 08 7fc00000 00
0 0 0 c0000000 bf800000 09 c0000000 00
0 1 0 abcd3c00 0000c000 0a ffffc000 00
1 1 0 7d004000 7d004200 0b ffff4200 00
0 1 0 00007d00 00003800 0c ffff3800 10
2 1 1 3c00c000 80000000 0d bc004000 00
3 1 1 7e003555 00008000 0e fe003555 00
4 1 1 bc00c000 80004000 0f 3c00c000 00
0 1 1 7d003c00 40004000 10 40003c00 10
1 1 1 7e010000 7c018000 11 7e000000 10
4 0 1 3f800000 80000000 12 bf800000 00
2 0 0 7f800001 80000000 13 ff800001 00
1 0 0 7f7fffff 7f800000 14 7f800000 00

//--- dv/fp_slice_tb.sv
`timescale 1ns/1ps
`include "fp_slice_defs.svh"

module fp_slice_tb;

  localparam int NUM_CASES  = 20;
  localparam int CASE_WORDS = 8;
  localparam int HS_LIMIT   = 100;
  localparam int DRAIN_LIMIT = 200;

  logic                    clk_i = 1'b0;
  logic                    rst_i;
  logic [`SLICE_WIDTH-1:0] operand_a_i;
  logic [`SLICE_WIDTH-1:0] operand_b_i;
  fp_op_pkg::operation_e   op_i;
  fp_fmt_pkg::fp_format_e  fmt_i;
  logic                    vectorial_op_i;
  logic [`TAG_WIDTH-1:0]   tag_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  logic                    flush_i;
  logic [`SLICE_WIDTH-1:0] result_o;
  fp_fmt_pkg::status_t     status_o;
  logic [`TAG_WIDTH-1:0]   tag_o;
  logic                    out_valid_o;
  logic                    out_ready_i = 1'b1;
  logic                    busy_o;

  logic [31:0] case_mem [0:NUM_CASES*CASE_WORDS-1];
  logic [31:0] rand_state = 32'h4956_2ec5;
  logic [1:0]  ready_mode = 2'd0;
  logic        latency_check = 1'b0;
  logic        track_input = 1'b0;
  int          cur_case = 0;
  int          cycle_cnt = 0;

  // Scoreboard of accepted items, oldest first
  logic [`SLICE_WIDTH-1:0] exp_result_q [$];
  logic [4:0]              exp_status_q [$];
  logic [`TAG_WIDTH-1:0]   exp_tag_q    [$];
  int                      exp_cycle_q  [$];
  logic [`SLICE_WIDTH-1:0] sb_result;
  logic [4:0]              sb_status;
  logic [`TAG_WIDTH-1:0]   sb_tag;
  int                      sb_cycle;

  int  mismatch_count = 0;
  int  extra_count = 0;
  int  flow_mismatch_count = 0;
  int  timeout_count = 0;
  bit  timed_out = 1'b0;

  always #20 clk_i = ~clk_i;

  fp_noncomp_slice u_dut (
    .clk_i, .rst_i, .operand_a_i, .operand_b_i, .op_i, .fmt_i, .vectorial_op_i,
    .tag_i, .in_valid_i, .in_ready_o, .flush_i, .result_o, .status_o, .tag_o,
    .out_valid_o, .out_ready_i, .busy_o
  );

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // Mode 0 always ready, 1 random back-pressure, 2 stalled
  always @(posedge clk_i) begin
    if (ready_mode == 2'd1) begin
      rand_state = next_random(rand_state);
      out_ready_i <= (rand_state[23:22] != 2'b00);
    end else begin
      out_ready_i <= (ready_mode == 2'd0);
    end
  end

  // --------------------------------------------------
  // Scoreboard
  // --------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_i && out_valid_o && out_ready_i) begin
      assert (exp_result_q.size() != 0) else begin
        extra_count++;
        $display("output at time %0t with no item in flight, tag %h", $time, tag_o);
      end
      if (exp_result_q.size() != 0) begin
        sb_result = exp_result_q.pop_front();
        sb_status = exp_status_q.pop_front();
        sb_tag    = exp_tag_q.pop_front();
        sb_cycle  = exp_cycle_q.pop_front();
        assert (result_o === sb_result) else begin
          mismatch_count++;
          $display("mismatch at time %0t: result %h, expected %h, tag %h",
                   $time, result_o, sb_result, sb_tag);
        end
        assert (status_o === sb_status) else begin
          mismatch_count++;
          $display("mismatch at time %0t: status %b, expected %b, tag %h",
                   $time, status_o, sb_status, sb_tag);
        end
        assert (tag_o === sb_tag) else begin
          mismatch_count++;
          $display("mismatch at time %0t: tag %h, expected %h", $time, tag_o, sb_tag);
        end
        if (latency_check) begin
          assert (cycle_cnt - sb_cycle == `NUM_PIPE_REGS) else begin
            mismatch_count++;
            $display("mismatch at time %0t: latency %0d cycles, tag %h",
                     $time, cycle_cnt - sb_cycle, sb_tag);
          end
        end
      end
    end
    if (!rst_i && in_valid_i && in_ready_o && track_input) begin
      exp_result_q.push_back(case_mem[cur_case*CASE_WORDS+6]);
      exp_status_q.push_back(case_mem[cur_case*CASE_WORDS+7][4:0]);
      exp_tag_q.push_back(tag_i);
      exp_cycle_q.push_back(cycle_cnt);
    end
  end

  // Called at a rising edge, returns at the accepting edge
  task automatic send_case(input int idx, input int pass_idx, input bit expect_out);
    int waited;
    int base;
    waited = 0;
    base   = idx * CASE_WORDS;
    if (!timed_out) begin
      op_i           <= fp_op_pkg::operation_e'(case_mem[base][2:0]);
      fmt_i          <= fp_fmt_pkg::fp_format_e'(case_mem[base+1][0]);
      vectorial_op_i <= case_mem[base+2][0];
      operand_a_i    <= case_mem[base+3];
      operand_b_i    <= case_mem[base+4];
      tag_i          <= case_mem[base+5][7:0] | {pass_idx[1:0], 6'd0};
      cur_case       <= idx;
      track_input    <= expect_out;
      in_valid_i     <= 1'b1;
      @(posedge clk_i);
      while (!in_ready_o && waited < HS_LIMIT) begin
        @(posedge clk_i);
        waited++;
      end
      if (!in_ready_o) begin
        timed_out = 1'b1;
        timeout_count++;
        $display("timeout waiting for in_ready_o on case %0d", idx);
      end
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    if (!timed_out) begin
      @(negedge clk_i);
      while ((exp_result_q.size() != 0 || busy_o) && waited < DRAIN_LIMIT) begin
        @(negedge clk_i);
        waited++;
      end
      if (exp_result_q.size() != 0 || busy_o) begin
        timed_out = 1'b1;
        timeout_count++;
        $display("timeout waiting for the pipeline to drain");
      end
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : main_flow
    rst_i          = 1'b1;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = fp_op_pkg::MIN;
    fmt_i          = fp_fmt_pkg::FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    $readmemh("dv/slice_cases.hex", case_mem);
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    assert (in_ready_o && !out_valid_o && !busy_o) else begin
      flow_mismatch_count++;
      $display("mismatch at time %0t: handshake state wrong after reset", $time);
    end

    // Back-to-back stream with fixed latency
    @(posedge clk_i);
    latency_check <= 1'b1;
    for (int idx = 0; idx < NUM_CASES; idx++) send_case(idx, 0, 1'b1);
    in_valid_i  <= 1'b0;
    track_input <= 1'b0;
    wait_for_drain();

    // Random back-pressure, order and count checked by the scoreboard
    @(posedge clk_i);
    latency_check <= 1'b0;
    ready_mode    <= 2'd1;
    for (int pass_idx = 1; pass_idx < 3; pass_idx++) begin
      for (int idx = 0; idx < NUM_CASES; idx++) send_case(idx, pass_idx, 1'b1);
    end
    in_valid_i  <= 1'b0;
    track_input <= 1'b0;
    wait_for_drain();

    // Fill both stages while stalled, then flush them away
    @(posedge clk_i);
    ready_mode <= 2'd2;
    repeat (2) @(posedge clk_i);
    send_case(12, 3, 1'b0);
    send_case(15, 3, 1'b0);
    in_valid_i <= 1'b0;
    @(posedge clk_i);
    assert (!in_ready_o) else begin
      flow_mismatch_count++;
      $display("mismatch at time %0t: in_ready_o high with every stage full", $time);
    end
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i    <= 1'b0;
    ready_mode <= 2'd0;
    wait_for_drain();
    @(posedge clk_i);
    send_case(13, 3, 1'b1);
    in_valid_i  <= 1'b0;
    track_input <= 1'b0;
    wait_for_drain();
    repeat (2) @(posedge clk_i);

    $display("%0d mismatches, %0d unexpected outputs, %0d timeouts",
             mismatch_count + flow_mismatch_count, extra_count, timeout_count);
    if (timed_out || (mismatch_count + flow_mismatch_count + extra_count) != 0) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

//--- dv/fp_slice_props.sv
`timescale 1ns/1ps
`include "fp_slice_defs.svh"

module fp_slice_props (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    flush_i,
  input logic                    out_valid_o,
  input logic                    out_ready_i,
  input logic [`SLICE_WIDTH-1:0] result_o
);

  // --------------------------------------------------
  // Output handshake
  // --------------------------------------------------

  // A stalled result holds until it is taken
  assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid_o && !out_ready_i && !flush_i) |=> (out_valid_o && $stable(result_o)))
    else $error("stalled output changed before it was taken");

  assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
    else $error("out_valid_o high after reset");

  // Flush empties every stage in one cycle
  assert property (@(posedge clk_i) flush_i |=> !out_valid_o)
    else $error("out_valid_o high in the cycle after flush");

endmodule

bind fp_noncomp_slice fp_slice_props u_props (
  .clk_i,
  .rst_i,
  .flush_i,
  .out_valid_o,
  .out_ready_i,
  .result_o
);

//--- source/fp_noncomp_slice.sv
`timescale 1ns/1ps
`include "fp_slice_defs.svh"

module fp_noncomp_slice (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Request
  input  logic [`SLICE_WIDTH-1:0] operand_a_i,
  input  logic [`SLICE_WIDTH-1:0] operand_b_i,
  input  fp_op_pkg::operation_e   op_i,
  input  fp_fmt_pkg::fp_format_e  fmt_i,
  input  logic                    vectorial_op_i,
  input  logic [`TAG_WIDTH-1:0]   tag_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic                    flush_i,
  // Response
  output logic [`SLICE_WIDTH-1:0] result_o,
  output fp_fmt_pkg::status_t     status_o,
  output logic [`TAG_WIDTH-1:0]   tag_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);

  localparam int unsigned HalfWidth = fp_fmt_pkg::FP16_WIDTH;

  logic                                    vector_op;
  fp_fmt_pkg::aux_t                        aux_data;
  logic                                    lane1_in_valid;
  logic                                    lane1_out_ready;
  logic                                    lane1_out_valid;
  logic [`SLICE_WIDTH-1:0]                 lane0_result;
  logic [HalfWidth-1:0]                    lane1_result;
  fp_fmt_pkg::aux_t                        lane0_aux;
  logic [`NUM_LANES-1:0][`SLICE_WIDTH-1:0] lane_result;
  fp_fmt_pkg::status_t [`NUM_LANES-1:0]    lane_status;
  logic [`NUM_LANES-1:0]                   lane_valid;
  logic [`NUM_LANES-1:0]                   lane_busy;

  // --------------------------------------------------
  // Input side
  // --------------------------------------------------

  // Only FP16 packs two values into the slice
  assign vector_op          = vectorial_op_i && (fmt_i == fp_fmt_pkg::FP16);
  assign aux_data.is_vector = vector_op;
  assign aux_data.fmt       = fmt_i;

  // Upper lane joins vector operations only
  assign lane1_in_valid = in_valid_i & vector_op;

  fp_noncomp_lane #(
    .HasFp32 ( 1'b1 )
  ) u_lane0 (
    .clk_i,
    .rst_i,
    .flush_i,
    .operand_a_i,
    .operand_b_i,
    .op_i,
    .fmt_i,
    .tag_i,
    .aux_i       ( aux_data       ),
    .in_valid_i,
    .in_ready_o,
    .out_valid_o ( lane_valid[0]  ),
    .out_ready_i,
    .result_o    ( lane0_result   ),
    .status_o    ( lane_status[0] ),
    .tag_o,
    .aux_o       ( lane0_aux      ),
    .busy_o      ( lane_busy[0]   )
  );

  fp_noncomp_lane #(
    .HasFp32 ( 1'b0 )
  ) u_lane1 (
    .clk_i,
    .rst_i,
    .flush_i,
    .operand_a_i ( operand_a_i[HalfWidth +: HalfWidth] ),
    .operand_b_i ( operand_b_i[HalfWidth +: HalfWidth] ),
    .op_i,
    .fmt_i,
    .tag_i,
    .aux_i       ( aux_data        ),
    .in_valid_i  ( lane1_in_valid  ),
    .in_ready_o  (                 ),
    .out_valid_o ( lane1_out_valid ),
    .out_ready_i ( lane1_out_ready ),
    .result_o    ( lane1_result    ),
    .status_o    ( lane_status[1]  ),
    .tag_o       (                 ),
    .aux_o       (                 ),
    .busy_o      ( lane_busy[1]    )
  );

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------

  // Lane 0 decides whether the upper lane takes part
  assign lane1_out_ready = out_ready_i & lane0_aux.is_vector;
  assign lane_valid[1]   = lane1_out_valid & lane0_aux.is_vector;

  assign lane_result[0] = lane0_result;
  assign lane_result[1] = {{(`SLICE_WIDTH - HalfWidth){1'b0}}, lane1_result};

  fp_result_packer u_packer (
    .lane_result_i ( lane_result ),
    .lane_status_i ( lane_status ),
    .lane_valid_i  ( lane_valid  ),
    .aux_i         ( lane0_aux   ),
    .result_o,
    .status_o
  );

  assign out_valid_o = lane_valid[0];
  assign busy_o      = |lane_busy;

endmodule

//--- source/fp_result_packer.sv
`timescale 1ns/1ps
`include "fp_slice_defs.svh"

module fp_result_packer (
  input  logic [`NUM_LANES-1:0][`SLICE_WIDTH-1:0] lane_result_i,
  input  fp_fmt_pkg::status_t [`NUM_LANES-1:0]    lane_status_i,
  input  logic [`NUM_LANES-1:0]                   lane_valid_i,
  input  fp_fmt_pkg::aux_t                        aux_i,
  output logic [`SLICE_WIDTH-1:0]                 result_o,
  output fp_fmt_pkg::status_t                     status_o
);

  localparam int unsigned HalfWidth = fp_fmt_pkg::FP16_WIDTH;

  // --------------------------------------------------
  // Result placement
  // --------------------------------------------------
  always_comb begin : place_results
    // Anything not written by a valid lane stays all ones
    result_o = '1;
    if (aux_i.fmt == fp_fmt_pkg::FP32) begin
      if (lane_valid_i[0]) begin
        result_o = lane_result_i[0];
      end
    end else begin
      for (int lane = 0; lane < `NUM_LANES; lane++) begin
        if (lane_valid_i[lane]) begin
          result_o[lane*HalfWidth +: HalfWidth] = lane_result_i[lane][HalfWidth-1:0];
        end
      end
    end
  end

  // Status of idle lanes is masked out
  always_comb begin : collapse_status
    status_o = '0;
    for (int lane = 0; lane < `NUM_LANES; lane++) begin
      if (lane_valid_i[lane]) begin
        status_o = status_o | lane_status_i[lane];
      end
    end
  end

endmodule

//--- source/fp_noncomp_lane.sv
`timescale 1ns/1ps
`include "fp_slice_defs.svh"

module fp_noncomp_lane #(
  parameter bit HasFp32 = 1'b1,
  localparam int unsigned LaneWidth =
      HasFp32 ? fp_fmt_pkg::FP32_WIDTH : fp_fmt_pkg::FP16_WIDTH
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   flush_i,
  input  logic [LaneWidth-1:0]   operand_a_i,
  input  logic [LaneWidth-1:0]   operand_b_i,
  input  fp_op_pkg::operation_e  op_i,
  input  fp_fmt_pkg::fp_format_e fmt_i,
  input  logic [`TAG_WIDTH-1:0]  tag_i,
  input  fp_fmt_pkg::aux_t       aux_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic [LaneWidth-1:0]   result_o,
  output fp_fmt_pkg::status_t    status_o,
  output logic [`TAG_WIDTH-1:0]  tag_o,
  output fp_fmt_pkg::aux_t       aux_o,
  output logic                   busy_o
);

  localparam int unsigned WideWidth = fp_fmt_pkg::FP32_WIDTH;
  localparam int unsigned HalfWidth = fp_fmt_pkg::FP16_WIDTH;
  localparam int unsigned Fp32Man   = fp_fmt_pkg::FP32_MAN_BITS;
  localparam int unsigned Fp16Man   = fp_fmt_pkg::FP16_MAN_BITS;

  logic                 is_fp32;
  logic [WideWidth-1:0] wide_op [2];
  logic [WideWidth-2:0] op_mag  [2];
  logic [1:0]           op_sign;
  logic [1:0]           op_nan;
  logic [1:0]           op_snan;
  logic [1:0]           op_zero;
  logic                 a_lt_b;
  logic                 inj_sign;
  logic [WideWidth-1:0] wide_result;
  logic [LaneWidth-1:0] lane_result;
  fp_fmt_pkg::status_t  lane_status;

  // A 16-bit lane always works on FP16
  assign is_fp32 = HasFp32 && (fmt_i == fp_fmt_pkg::FP32);

  // --------------------------------------------------
  // Operand classification
  // --------------------------------------------------
  always_comb begin : classify
    wide_op[0] = '0;
    wide_op[1] = '0;
    wide_op[0][LaneWidth-1:0] = operand_a_i;
    wide_op[1][LaneWidth-1:0] = operand_b_i;
    for (int i = 0; i < 2; i++) begin
      op_mag[i] = '0;
      if (is_fp32) begin
        op_sign[i] = wide_op[i][WideWidth-1];
        op_mag[i]  = wide_op[i][WideWidth-2:0];
        op_nan[i]  = (&wide_op[i][WideWidth-2:Fp32Man]) && (|wide_op[i][Fp32Man-1:0]);
        op_snan[i] = op_nan[i] && !wide_op[i][Fp32Man-1];
      end else begin
        op_sign[i] = wide_op[i][HalfWidth-1];
        op_mag[i][HalfWidth-2:0] = wide_op[i][HalfWidth-2:0];
        op_nan[i]  = (&wide_op[i][HalfWidth-2:Fp16Man]) && (|wide_op[i][Fp16Man-1:0]);
        op_snan[i] = op_nan[i] && !wide_op[i][Fp16Man-1];
      end
      op_zero[i] = (op_mag[i] == '0);
    end
  end

  // Sign-magnitude ordering
  always_comb begin : compare
    if (op_zero[0] && op_zero[1]) begin
      // -0 orders below +0
      a_lt_b = op_sign[0] && !op_sign[1];
    end else if (op_sign[0] != op_sign[1]) begin
      a_lt_b = op_sign[0];
    end else if (op_sign[0]) begin
      a_lt_b = op_mag[0] > op_mag[1];
    end else begin
      a_lt_b = op_mag[0] < op_mag[1];
    end
  end

  // --------------------------------------------------
  // Min/max and sign injection
  // --------------------------------------------------
  always_comb begin : compute
    wide_result = wide_op[0];
    inj_sign    = op_sign[1];
    lane_status = '0;
    case (op_i)
      fp_op_pkg::MIN, fp_op_pkg::MAX: begin
        if (op_nan[0] && op_nan[1]) begin
          wide_result = fp_fmt_pkg::FP32_QNAN;
          if (!is_fp32) begin
            wide_result[HalfWidth-1:0] = fp_fmt_pkg::FP16_QNAN;
          end
        end else if (op_nan[0]) begin
          wide_result = wide_op[1];
        end else if (op_nan[1]) begin
          wide_result = wide_op[0];
        end else if ((op_i == fp_op_pkg::MIN) == a_lt_b) begin
          wide_result = wide_op[0];
        end else begin
          wide_result = wide_op[1];
        end
        // Only signaling NaNs raise invalid
        lane_status.NV = |op_snan;
      end
      fp_op_pkg::SGNJ, fp_op_pkg::SGNJN, fp_op_pkg::SGNJX: begin
        if (op_i == fp_op_pkg::SGNJN) begin
          inj_sign = !op_sign[1];
        end else if (op_i == fp_op_pkg::SGNJX) begin
          inj_sign = op_sign[0] ^ op_sign[1];
        end
        if (is_fp32) begin
          wide_result[WideWidth-1] = inj_sign;
        end else begin
          wide_result[HalfWidth-1] = inj_sign;
        end
      end
      default: wide_result = wide_op[0];
    endcase
  end

  assign lane_result = wide_result[LaneWidth-1:0];

  fp_lane_pipe #(
    .DataWidth ( LaneWidth )
  ) u_pipe (
    .clk_i,
    .rst_i,
    .flush_i,
    .in_valid_i,
    .in_ready_o,
    .in_result_i  ( lane_result ),
    .in_status_i  ( lane_status ),
    .in_tag_i     ( tag_i       ),
    .in_aux_i     ( aux_i       ),
    .out_valid_o,
    .out_ready_i,
    .out_result_o ( result_o    ),
    .out_status_o ( status_o    ),
    .out_tag_o    ( tag_o       ),
    .out_aux_o    ( aux_o       ),
    .busy_o
  );

endmodule

//--- source/fp_lane_pipe.sv
`timescale 1ns/1ps
`include "fp_slice_defs.svh"

module fp_lane_pipe #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  // Upstream side
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [DataWidth-1:0]  in_result_i,
  input  fp_fmt_pkg::status_t   in_status_i,
  input  logic [`TAG_WIDTH-1:0] in_tag_i,
  input  fp_fmt_pkg::aux_t      in_aux_i,
  // Downstream side
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [DataWidth-1:0]  out_result_o,
  output fp_fmt_pkg::status_t   out_status_o,
  output logic [`TAG_WIDTH-1:0] out_tag_o,
  output fp_fmt_pkg::aux_t      out_aux_o,
  output logic                  busy_o
);

  // Index i holds the item after i register stages
  logic [DataWidth-1:0]    pipe_result_q [0:`NUM_PIPE_REGS];
  fp_fmt_pkg::status_t     pipe_status_q [0:`NUM_PIPE_REGS];
  logic [`TAG_WIDTH-1:0]   pipe_tag_q    [0:`NUM_PIPE_REGS];
  fp_fmt_pkg::aux_t        pipe_aux_q    [0:`NUM_PIPE_REGS];
  logic [0:`NUM_PIPE_REGS] pipe_valid_q;
  logic [0:`NUM_PIPE_REGS] pipe_ready;

  // Stage 0 is the input itself
  assign pipe_result_q[0] = in_result_i;
  assign pipe_status_q[0] = in_status_i;
  assign pipe_tag_q[0]    = in_tag_i;
  assign pipe_aux_q[0]    = in_aux_i;
  assign pipe_valid_q[0]  = in_valid_i;

  // --------------------------------------------------
  // Register stages
  // --------------------------------------------------
  for (genvar i = 0; i < `NUM_PIPE_REGS; i++) begin : gen_stage
    logic reg_ena;

    // Advance when the next stage moves on or only holds a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid_q[i+1];
    assign reg_ena       = pipe_ready[i] & pipe_valid_q[i];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid_q[i+1] <= pipe_valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin
        pipe_result_q[i+1] <= pipe_result_q[i];
        pipe_status_q[i+1] <= pipe_status_q[i];
        pipe_tag_q[i+1]    <= pipe_tag_q[i];
        pipe_aux_q[i+1]    <= pipe_aux_q[i];
      end
    end
  end

  // Ready enters from the downstream side
  assign pipe_ready[`NUM_PIPE_REGS] = out_ready_i;

  assign in_ready_o   = pipe_ready[0];
  assign out_valid_o  = pipe_valid_q[`NUM_PIPE_REGS];
  assign out_result_o = pipe_result_q[`NUM_PIPE_REGS];
  assign out_status_o = pipe_status_q[`NUM_PIPE_REGS];
  assign out_tag_o    = pipe_tag_q[`NUM_PIPE_REGS];
  assign out_aux_o    = pipe_aux_q[`NUM_PIPE_REGS];

  // Any registered item counts as in flight
  assign busy_o = |pipe_valid_q[1:`NUM_PIPE_REGS];

endmodule

//--- source/fp_op_pkg.sv
package fp_op_pkg;

  // Non-computational operations
  // Sign injection variants have their own codes
  typedef enum logic [2:0] {
    MIN   = 3'd0,
    MAX   = 3'd1,
    SGNJ  = 3'd2,
    SGNJN = 3'd3,
    SGNJX = 3'd4
  } operation_e;

endpackage

//--- source/fp_fmt_pkg.sv
package fp_fmt_pkg;

  // --------------------------------------------------
  // Formats and flags
  // --------------------------------------------------

  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  // RISC-V fflags order
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // Travels with each item down the lane pipeline
  typedef struct packed {
    logic       is_vector;
    fp_format_e fmt;
  } aux_t;

  // Per-format field widths
  localparam int unsigned FP32_WIDTH    = 32;
  localparam int unsigned FP32_EXP_BITS = 8;
  localparam int unsigned FP32_MAN_BITS = 23;
  localparam int unsigned FP16_WIDTH    = 16;
  localparam int unsigned FP16_EXP_BITS = 5;
  localparam int unsigned FP16_MAN_BITS = 10;

  // Canonical quiet NaNs
  localparam logic [FP32_WIDTH-1:0] FP32_QNAN = 32'h7fc0_0000;
  localparam logic [FP16_WIDTH-1:0] FP16_QNAN = 16'h7e00;

endpackage

//--- source/fp_slice_defs.svh
`ifndef FP_SLICE_DEFS_SVH
`define FP_SLICE_DEFS_SVH

// --------------------------------------------------
// Slice geometry
// --------------------------------------------------

// Datapath width, one FP32 value or two FP16 values
`define SLICE_WIDTH 32

// Width of the tag carried alongside each operation
`define TAG_WIDTH 8

// Slice width over the narrowest format width
`define NUM_LANES 2

// Register stages in every lane pipeline
`define NUM_PIPE_REGS 2

`endif
